/* hw/exu_macros.svh */
// execute subsystem sizing
// data width, register index width and OITF depth shared by packages and RTL

`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// data and address width
`define XLEN        32

// register file index
`define RFIDX_WIDTH 5

// outstanding long-pipe instructions, tag is log2 of depth
`define OITF_DEPTH  4
`define ITAG_WIDTH  2

`endif

/* hw/exu_pkg.sv */
// execute subsystem types
// instruction formats, decoded operation and the load/store request

`include "exu_macros.svh"

package exu_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // five codes, so three bits
    typedef enum logic [2:0] {
        OP_ADD,
        OP_ADDI,
        OP_LW,
        OP_SW,
        OP_ILL
    } exu_op_e;

    // I layout, rd sits where the S layout keeps imm_lo
    typedef struct packed {
        logic [11:0]             imm;
        logic [`RFIDX_WIDTH-1:0] rs1;
        logic [2:0]              funct3;
        logic [`RFIDX_WIDTH-1:0] rd;
        logic [6:0]              opcode;
    } instr_i_t;

    // S layout, imm_hi doubles as funct7 for R-type
    typedef struct packed {
        logic [6:0]              imm_hi;
        logic [`RFIDX_WIDTH-1:0] rs2;
        logic [`RFIDX_WIDTH-1:0] rs1;
        logic [2:0]              funct3;
        logic [4:0]              imm_lo;
        logic [6:0]              opcode;
    } instr_s_t;

    typedef union packed {
        instr_i_t i;
        instr_s_t s;
    } exu_instr_u;

    // one queued long-pipe access
    typedef struct packed {
        logic [`ITAG_WIDTH-1:0] tag;
        logic                   write;
        logic [`XLEN-1:0]       addr;
        logic [`XLEN-1:0]       wdata;
    } lsu_req_t;

endpackage

/* hw/apb_pkg.sv */
// APB master types
// transfer phase encoding and the address/data bundle of one transfer

`include "exu_macros.svh"

package apb_pkg;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_e;

    typedef struct packed {
        logic [`XLEN-1:0] paddr;
        logic             pwrite;
        logic [`XLEN-1:0] pwdata;
    } apb_req_t;

endpackage

/* hw/exu_disp_if.sv */
// dispatch to OITF link
// register usage of the dispatching instruction, answered by
// OITF readiness, allocation tag and dependency matches

`timescale 1ns/1ps
`include "exu_macros.svh"

interface exu_disp_if;

    logic                    disp_ena;
    logic                    rs1en;
    logic                    rs2en;
    logic                    rdwen;
    logic [`RFIDX_WIDTH-1:0] rs1idx;
    logic [`RFIDX_WIDTH-1:0] rs2idx;
    logic [`RFIDX_WIDTH-1:0] rdidx;

    logic                    disp_ready;
    logic [`ITAG_WIDTH-1:0]  dis_ptr;
    logic                    match_rs1;
    logic                    match_rs2;
    logic                    match_rd;

    modport disp (
        output disp_ena, rs1en, rs2en, rdwen, rs1idx, rs2idx, rdidx,
        input  disp_ready, dis_ptr, match_rs1, match_rs2, match_rd
    );

    modport oitf (
        input  disp_ena, rs1en, rs2en, rdwen, rs1idx, rs2idx, rdidx,
        output disp_ready, dis_ptr, match_rs1, match_rs2, match_rd
    );

endinterface

/* hw/exu_disp.sv */
// dispatch stage
// decodes ADD/ADDI/LW/SW, reads operands, stalls on OITF hazards,
// executes ALU ops in place and hands loads/stores to the LSU

`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_disp (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    instr_valid,
    input  exu_pkg::exu_instr_u     instr_word,
    output logic                    instr_ready,
    output logic [`RFIDX_WIDTH-1:0] rs1_idx,
    output logic [`RFIDX_WIDTH-1:0] rs2_idx,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,
    input  logic                    alu_grant,
    output logic                    alu_wen,
    output logic [`RFIDX_WIDTH-1:0] alu_rdidx,
    output logic [`XLEN-1:0]        alu_data,
    output logic                    lsu_valid,
    output exu_pkg::lsu_req_t       lsu_req,
    exu_disp_if.disp                oitf
);
    import exu_pkg::*;

    exu_op_e          op;
    logic             is_alu;
    logic             is_long;
    logic             hazard;
    logic             fire;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;

    // ========================================================================
    // decode
    // ========================================================================
    always_comb begin
        op = OP_ILL;
        case (instr_word.i.opcode)
            OPC_OP: begin
                if (instr_word.i.funct3 == 3'b000 && instr_word.s.imm_hi == 7'b0) begin
                    op = OP_ADD;
                end
            end
            OPC_OPIMM: begin
                if (instr_word.i.funct3 == 3'b000) begin
                    op = OP_ADDI;
                end
            end
            OPC_LOAD: begin
                if (instr_word.i.funct3 == 3'b010) begin
                    op = OP_LW;
                end
            end
            OPC_STORE: begin
                if (instr_word.s.funct3 == 3'b010) begin
                    op = OP_SW;
                end
            end
            default: op = OP_ILL;
        endcase
    end

    assign is_alu  = (op == OP_ADD) || (op == OP_ADDI);
    assign is_long = (op == OP_LW) || (op == OP_SW);

    assign imm_i = {{(`XLEN-12){instr_word.i.imm[11]}}, instr_word.i.imm};
    assign imm_s = {{(`XLEN-12){instr_word.s.imm_hi[6]}},
                    instr_word.s.imm_hi, instr_word.s.imm_lo};

    // register usage as seen by the OITF
    assign rs1_idx      = instr_word.i.rs1;
    assign rs2_idx      = instr_word.s.rs2;
    assign oitf.rs1idx  = rs1_idx;
    assign oitf.rs2idx  = rs2_idx;
    assign oitf.rdidx   = instr_word.i.rd;
    assign oitf.rs1en   = is_alu || is_long;
    assign oitf.rs2en   = (op == OP_ADD) || (op == OP_SW);
    // x0 destinations never create a dependency
    assign oitf.rdwen   = (is_alu || op == OP_LW) && (instr_word.i.rd != '0);

    // ========================================================================
    // stall and issue
    // ========================================================================
    assign hazard = oitf.match_rs1 || oitf.match_rs2 || oitf.match_rd;

    // illegal words are accepted and dropped
    assign instr_ready = !hazard &&
                         (is_long ? oitf.disp_ready : (is_alu ? alu_grant : 1'b1));
    assign fire        = instr_valid && instr_ready;

    assign alu_wen   = fire && is_alu;
    assign alu_rdidx = instr_word.i.rd;
    assign alu_data  = rs1_data + ((op == OP_ADD) ? rs2_data : imm_i);

    assign lsu_valid     = fire && is_long;
    assign oitf.disp_ena = lsu_valid;

    assign lsu_req.tag   = oitf.dis_ptr;
    assign lsu_req.write = (op == OP_SW);
    assign lsu_req.addr  = rs1_data + ((op == OP_SW) ? imm_s : imm_i);
    assign lsu_req.wdata = rs2_data;

    // each long-pipe issue takes the next OITF tag
    a_alloc_tag: assert property (@(posedge clk) disable iff (reset)
        lsu_valid |=> (oitf.dis_ptr == $past(oitf.dis_ptr) + 1'b1));

endmodule

/* hw/exu_oitf.sv */
// outstanding instruction track FIFO
// one entry per load/store in flight, allocated at dispatch and freed
// at retirement; entry destinations are matched against new instructions

`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_oitf (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ret_ena,
    output logic [`ITAG_WIDTH-1:0]  ret_ptr,
    output logic [`RFIDX_WIDTH-1:0] ret_rdidx,
    output logic                    ret_rdwen,
    output logic                    oitf_empty,
    exu_disp_if.oitf                disp
);

    logic [`ITAG_WIDTH-1:0]  alc_ptr;
    logic                    alc_flg;
    logic                    ret_flg;
    logic                    oitf_full;
    logic [`OITF_DEPTH-1:0]  vld;
    logic [`OITF_DEPTH-1:0]  rdwen_q;
    logic [`RFIDX_WIDTH-1:0] rdidx_q [`OITF_DEPTH];
    logic [`OITF_DEPTH-1:0]  hit_rs1;
    logic [`OITF_DEPTH-1:0]  hit_rs2;
    logic [`OITF_DEPTH-1:0]  hit_rd;

    // ========================================================================
    // pointers
    // ========================================================================
    // the wrap flag rides above the pointer as the carry bit
    always_ff @(posedge clk) begin
        if (reset) begin
            alc_ptr <= '0;
            alc_flg <= 1'b0;
            ret_ptr <= '0;
            ret_flg <= 1'b0;
        end else begin
            if (disp.disp_ena) begin
                {alc_flg, alc_ptr} <= {alc_flg, alc_ptr} + 1'b1;
            end
            if (ret_ena) begin
                {ret_flg, ret_ptr} <= {ret_flg, ret_ptr} + 1'b1;
            end
        end
    end

    assign oitf_empty = (alc_ptr == ret_ptr) && (alc_flg == ret_flg);
    assign oitf_full  = (alc_ptr == ret_ptr) && (alc_flg != ret_flg);

    assign disp.disp_ready = !oitf_full;
    assign disp.dis_ptr    = alc_ptr;

    // ========================================================================
    // entries
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            vld <= '0;
        end else begin
            for (int i = 0; i < `OITF_DEPTH; i++) begin
                if (disp.disp_ena && alc_ptr == i) begin
                    vld[i] <= 1'b1;
                end else if (ret_ena && ret_ptr == i) begin
                    vld[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (disp.disp_ena) begin
            rdidx_q[alc_ptr] <= disp.rdidx;
            rdwen_q[alc_ptr] <= disp.rdwen;
        end
    end

    // dependency check against every live destination
    always_comb begin
        for (int i = 0; i < `OITF_DEPTH; i++) begin
            hit_rs1[i] = vld[i] && rdwen_q[i] && disp.rs1en && (rdidx_q[i] == disp.rs1idx);
            hit_rs2[i] = vld[i] && rdwen_q[i] && disp.rs2en && (rdidx_q[i] == disp.rs2idx);
            hit_rd[i]  = vld[i] && rdwen_q[i] && disp.rdwen && (rdidx_q[i] == disp.rdidx);
        end
    end

    assign disp.match_rs1 = |hit_rs1;
    assign disp.match_rs2 = |hit_rs2;
    assign disp.match_rd  = |hit_rd;

    assign ret_rdidx = rdidx_q[ret_ptr];
    assign ret_rdwen = rdwen_q[ret_ptr];

    a_no_ret_empty: assert property (@(posedge clk) disable iff (reset)
        ret_ena |-> !oitf_empty);

    a_no_alc_full: assert property (@(posedge clk) disable iff (reset)
        disp.disp_ena |-> !oitf_full);

endmodule

/* hw/exu_regfile.sv */
// integer register file
// x1..x31 with two operand read ports, one write port and a debug read port;
// x0 is hardwired to zero

`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_regfile (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`RFIDX_WIDTH-1:0] rs1_idx,
    input  logic [`RFIDX_WIDTH-1:0] rs2_idx,
    output logic [`XLEN-1:0]        rs1_data,
    output logic [`XLEN-1:0]        rs2_data,
    input  logic                    wen,
    input  logic [`RFIDX_WIDTH-1:0] wr_idx,
    input  logic [`XLEN-1:0]        wr_data,
    input  logic [`RFIDX_WIDTH-1:0] dbg_rdidx,
    output logic [`XLEN-1:0]        dbg_rdata
);

    localparam int NREGS = 1 << `RFIDX_WIDTH;

    logic [`XLEN-1:0] regs [1:NREGS-1];

    function automatic logic [`XLEN-1:0] rd_reg(input logic [`RFIDX_WIDTH-1:0] idx);
        return (idx == '0) ? '0 : regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs1_data  = rd_reg(rs1_idx);
    assign rs2_data  = rd_reg(rs2_idx);
    assign dbg_rdata = rd_reg(dbg_rdidx);

endmodule

/* hw/exu_lsu.sv */
// load/store unit
// in-order request queue drained one APB transfer at a time;
// each completed transfer retires the oldest OITF entry

`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_lsu (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   lsu_valid,
    input  exu_pkg::lsu_req_t      lsu_req,
    input  logic [`ITAG_WIDTH-1:0] ret_ptr,
    output logic                   ret_ena,
    output logic                   ld_wen,
    output logic [`XLEN-1:0]       ld_data,
    output logic                   psel,
    output logic                   penable,
    output logic                   pwrite,
    output logic [`XLEN-1:0]       paddr,
    output logic [`XLEN-1:0]       pwdata,
    input  logic [`XLEN-1:0]       prdata,
    input  logic                   pready
);
    import exu_pkg::*;
    import apb_pkg::*;

    lsu_req_t               queue [`OITF_DEPTH];
    lsu_req_t               head;
    logic [`ITAG_WIDTH-1:0] wr_ptr;
    logic [`ITAG_WIDTH-1:0] rd_ptr;
    logic [`ITAG_WIDTH:0]   count;
    logic                   done;
    apb_state_e             state;
    apb_req_t               apb_req;

    // ========================================================================
    // request queue
    // ========================================================================
    // same depth as the OITF, so a push always finds room
    always_ff @(posedge clk) begin
        if (lsu_valid) begin
            queue[wr_ptr] <= lsu_req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (lsu_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (done) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({lsu_valid, done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head = queue[rd_ptr];

    // ========================================================================
    // APB master
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= APB_IDLE;
        end else begin
            case (state)
                APB_IDLE:   if (count != '0) state <= APB_SETUP;
                APB_SETUP:  state <= APB_ACCESS;
                APB_ACCESS: if (pready) state <= APB_IDLE;
                default:    state <= APB_IDLE;
            endcase
        end
    end

    // head stays put until its transfer completes
    assign apb_req.paddr  = head.addr;
    assign apb_req.pwrite = head.write;
    assign apb_req.pwdata = head.wdata;

    assign psel    = (state != APB_IDLE);
    assign penable = (state == APB_ACCESS);
    assign paddr   = apb_req.paddr;
    assign pwrite  = apb_req.pwrite;
    assign pwdata  = apb_req.pwdata;

    assign done    = penable && pready;
    assign ret_ena = done;
    assign ld_wen  = done && !head.write;
    assign ld_data = prdata;

    // queue and OITF retire in the same order
    a_ret_tag: assert property (@(posedge clk) disable iff (reset)
        ret_ena |-> (head.tag == ret_ptr));

endmodule

/* hw/exu_wbck.sv */
// write-back arbiter
// merges load retirement and ALU results onto the single register write
// port, loads first

`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_wbck (
    input  logic                    ld_wen,
    input  logic [`RFIDX_WIDTH-1:0] ld_rdidx,
    input  logic [`XLEN-1:0]        ld_data,
    input  logic                    alu_wen,
    input  logic [`RFIDX_WIDTH-1:0] alu_rdidx,
    input  logic [`XLEN-1:0]        alu_data,
    output logic                    alu_grant,
    output logic                    wen,
    output logic [`RFIDX_WIDTH-1:0] wr_idx,
    output logic [`XLEN-1:0]        wr_data
);

    // ALU loses whenever a load retires
    assign alu_grant = !ld_wen;

    assign wen     = ld_wen || alu_wen;
    assign wr_idx  = ld_wen ? ld_rdidx : alu_rdidx;
    assign wr_data = ld_wen ? ld_data : alu_data;

    // dispatch must hold ALU ops while the grant is low
    a_alu_grant: assert final (!(alu_wen && !alu_grant))
        else $error("ALU write without grant");

endmodule

/* hw/exu_top.sv */
// execute subsystem top
// dispatch, OITF, register file, load/store unit and write-back,
// with an instruction stream in, an APB master out and a debug read port

`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    instr_valid,
    input  logic [`XLEN-1:0]        instr_word,
    output logic                    instr_ready,
    output logic                    psel,
    output logic                    penable,
    output logic                    pwrite,
    output logic [`XLEN-1:0]        paddr,
    output logic [`XLEN-1:0]        pwdata,
    input  logic [`XLEN-1:0]        prdata,
    input  logic                    pready,
    input  logic [`RFIDX_WIDTH-1:0] dbg_rdidx,
    output logic [`XLEN-1:0]        dbg_rdata
);
    import exu_pkg::*;

    logic [`RFIDX_WIDTH-1:0] rs1_idx;
    logic [`RFIDX_WIDTH-1:0] rs2_idx;
    logic [`XLEN-1:0]        rs1_data;
    logic [`XLEN-1:0]        rs2_data;
    logic                    alu_grant;
    logic                    alu_wen;
    logic [`RFIDX_WIDTH-1:0] alu_rdidx;
    logic [`XLEN-1:0]        alu_data;
    logic                    lsu_valid;
    lsu_req_t                lsu_req;
    logic                    ret_ena;
    logic [`ITAG_WIDTH-1:0]  ret_ptr;
    logic [`RFIDX_WIDTH-1:0] ret_rdidx;
    logic                    ret_rdwen;
    logic                    ld_wen;
    logic                    ld_rd_wen;
    logic [`XLEN-1:0]        ld_data;
    logic                    wb_wen;
    logic [`RFIDX_WIDTH-1:0] wb_idx;
    logic [`XLEN-1:0]        wb_data;

    exu_disp_if disp_if ();

    // loads to x0 retire without a register write
    assign ld_rd_wen = ld_wen && ret_rdwen;

    exu_disp exu_disp_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .instr_ready (instr_ready),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_grant   (alu_grant),
        .alu_wen     (alu_wen),
        .alu_rdidx   (alu_rdidx),
        .alu_data    (alu_data),
        .lsu_valid   (lsu_valid),
        .lsu_req     (lsu_req),
        .oitf        (disp_if.disp)
    );

    exu_oitf exu_oitf_i (
        .clk        (clk),
        .reset      (reset),
        .ret_ena    (ret_ena),
        .ret_ptr    (ret_ptr),
        .ret_rdidx  (ret_rdidx),
        .ret_rdwen  (ret_rdwen),
        .oitf_empty (),
        .disp       (disp_if.oitf)
    );

    exu_regfile exu_regfile_i (
        .clk       (clk),
        .reset     (reset),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .wen       (wb_wen),
        .wr_idx    (wb_idx),
        .wr_data   (wb_data),
        .dbg_rdidx (dbg_rdidx),
        .dbg_rdata (dbg_rdata)
    );

    exu_lsu exu_lsu_i (
        .clk       (clk),
        .reset     (reset),
        .lsu_valid (lsu_valid),
        .lsu_req   (lsu_req),
        .ret_ptr   (ret_ptr),
        .ret_ena   (ret_ena),
        .ld_wen    (ld_wen),
        .ld_data   (ld_data),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready)
    );

    exu_wbck exu_wbck_i (
        .ld_wen    (ld_rd_wen),
        .ld_rdidx  (ret_rdidx),
        .ld_data   (ld_data),
        .alu_wen   (alu_wen),
        .alu_rdidx (alu_rdidx),
        .alu_data  (alu_data),
        .alu_grant (alu_grant),
        .wen       (wb_wen),
        .wr_idx    (wb_idx),
        .wr_data   (wb_data)
    );

endmodule

/* verification/apb_mem_model.sv */
// APB slave memory for the execute subsystem testbench
// 256 words addressed by paddr[9:2], 0..MAX_WAIT wait states per transfer
// drawn from an LCG; hold keeps pready low until released

`timescale 1ns/1ps

module apb_mem_model #(
    parameter logic [31:0] SEED     = 32'h1,
    parameter int          MAX_WAIT = 3
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        hold,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready
);

    logic [31:0] mem [256];
    logic [31:0] lcg;
    int          wait_cnt;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // fill pattern over the whole word index
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h9e37_79b9 * (i + 1);
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            lcg      <= SEED;
            wait_cnt <= 0;
        end else if (psel && !penable) begin
            // setup phase, draw wait states for this transfer
            lcg      <= lcg_next(lcg);
            wait_cnt <= (lcg >> 16) % (MAX_WAIT + 1);
        end else if (psel && penable && !hold && wait_cnt != 0) begin
            wait_cnt <= wait_cnt - 1;
        end
        if (psel && penable && pready && pwrite) begin
            mem[paddr[9:2]] <= pwdata;
        end
    end

    assign pready = !hold && (wait_cnt == 0);
    assign prdata = mem[paddr[9:2]];

endmodule

/* verification/exu_tb.sv */
// testbench for the execute subsystem
// directed tests for reset state, ALU ops, stores and loads over APB,
// load hazards and OITF back-pressure, checked against a reference
// register file and memory kept here

`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_tb;

    localparam logic [31:0] LCG_SEED  = 32'hc271_5cec;
    localparam int          MAX_WAIT  = 3;
    localparam int          TIMEOUT   = 200;
    localparam int          MEM_WORDS = 256;

    logic                    clk;
    logic                    reset;
    logic                    instr_valid;
    logic [`XLEN-1:0]        instr_word;
    logic                    instr_ready;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`XLEN-1:0]        paddr;
    logic [`XLEN-1:0]        pwdata;
    logic [`XLEN-1:0]        prdata;
    logic                    pready;
    logic [`RFIDX_WIDTH-1:0] dbg_rdidx;
    logic [`XLEN-1:0]        dbg_rdata;
    logic                    hold;

    logic [`XLEN-1:0] ref_regs [32];
    logic [`XLEN-1:0] ref_mem [MEM_WORDS];
    logic [`XLEN-1:0] exp_wr [$];
    logic [`XLEN-1:0] got_wr [$];
    int               checks;
    int               errors;
    int               test_base;

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    exu_top exu_top_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .instr_ready (instr_ready),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .dbg_rdidx   (dbg_rdidx),
        .dbg_rdata   (dbg_rdata)
    );

    apb_mem_model #(.SEED(LCG_SEED), .MAX_WAIT(MAX_WAIT)) mem_model_i (
        .clk     (clk),
        .reset   (reset),
        .hold    (hold),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    // APB writes in completion order
    always @(posedge clk) begin
        if (!reset && psel && penable && pready && pwrite) begin
            got_wr.push_back(paddr);
        end
    end

    // ========================================================================
    // encoding and reference helpers
    // ========================================================================
    function automatic logic [31:0] sext(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] r_type(
        input logic [4:0] rd,
        input logic [4:0] rs1,
        input logic [4:0] rs2
    );
        return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(
        input logic [6:0]  opc,
        input logic [2:0]  f3,
        input logic [4:0]  rd,
        input logic [4:0]  rs1,
        input logic [11:0] imm
    );
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(
        input logic [4:0]  rs2,
        input logic [4:0]  rs1,
        input logic [11:0] imm
    );
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout: %s did not happen within %0d cycles at %0t ns", what, TIMEOUT, $time);
        $display("** FAIL **");
        $finish;
    endtask

    // called in the low phase, returns at the negedge after acceptance
    task automatic issue(input logic [31:0] word);
        int waited;
        waited      = 0;
        instr_valid = 1'b1;
        instr_word  = word;
        #1;
        while (!instr_ready && waited < TIMEOUT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!instr_ready) begin
            timeout_abort("instr_ready");
        end else begin
            @(posedge clk);
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    task automatic addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        issue(i_type(7'b0010011, 3'b000, rd, rs1, imm));
        if (rd != 0) begin
            ref_regs[rd] = ref_regs[rs1] + sext(imm);
        end
    endtask

    task automatic add(input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        issue(r_type(rd, rs1, rs2));
        if (rd != 0) begin
            ref_regs[rd] = ref_regs[rs1] + ref_regs[rs2];
        end
    endtask

    task automatic lw(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] addr;
        addr = ref_regs[rs1] + sext(imm);
        issue(i_type(7'b0000011, 3'b010, rd, rs1, imm));
        if (rd != 0) begin
            ref_regs[rd] = ref_mem[addr[9:2]];
        end
    endtask

    task automatic sw(input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] addr;
        addr = ref_regs[rs1] + sext(imm);
        issue(s_type(rs2, rs1, imm));
        ref_mem[addr[9:2]] = ref_regs[rs2];
        exp_wr.push_back(addr);
    endtask

    // two idle negedges in a row means the LSU queue is empty
    task automatic drain();
        int idle;
        int waited;
        idle   = 0;
        waited = 0;
        while (idle < 2 && waited < TIMEOUT) begin
            idle = psel ? 0 : idle + 1;
            @(negedge clk);
            waited++;
        end
        if (idle < 2) begin
            timeout_abort("LSU drain");
        end
    endtask

    task automatic check_reg(input logic [4:0] idx);
        dbg_rdidx = idx;
        #1;
        check($sformatf("x%0d", idx), dbg_rdata, ref_regs[idx]);
        @(negedge clk);
    endtask

    task automatic check_regs();
        for (int i = 0; i < 32; i++) begin
            check_reg(i);
        end
    endtask

    task automatic check_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            check($sformatf("mem[%0d]", i), mem_model_i.mem[i], ref_mem[i]);
        end
    endtask

    task automatic begin_test();
        test_base = errors;
    endtask

    task automatic end_test(input string name);
        $display("test %-13s finished with %0d errors", name, errors - test_base);
    endtask

    // ========================================================================
    // directed tests
    // ========================================================================
    task automatic reset_state();
        begin_test();
        check("instr_ready", instr_ready, 1);
        check("psel", psel, 0);
        check("penable", penable, 0);
        check_regs();
        end_test("reset_state");
    endtask

    task automatic alu_ops();
        begin_test();
        addi(1, 0, 12'd5);
        check_reg(1);
        addi(2, 1, 12'hffd);
        check_reg(2);
        add(3, 1, 2);
        check_reg(3);
        // x0 stays zero
        addi(0, 1, 12'd7);
        check_reg(0);
        add(4, 3, 3);
        check_reg(4);
        addi(5, 4, 12'h7ff);
        check_reg(5);
        addi(6, 5, 12'h800);
        check_reg(6);
        add(0, 5, 6);
        check_reg(0);
        add(7, 6, 0);
        check_reg(7);
        check_regs();
        end_test("alu_ops");
    endtask

    task automatic store_load();
        begin_test();
        addi(8, 0, 12'h100);
        addi(9, 0, 12'h123);
        addi(10, 0, 12'h9ab);
        add(11, 9, 10);
        sw(9, 8, 12'h000);
        sw(10, 8, 12'h004);
        sw(11, 8, 12'h040);
        sw(10, 8, 12'hff8);
        lw(12, 8, 12'h000);
        lw(13, 8, 12'h004);
        lw(14, 8, 12'h040);
        lw(15, 8, 12'hff8);
        // untouched word keeps its fill value
        lw(16, 0, 12'h080);
        drain();
        check_regs();
        check_memory();
        end_test("store_load");
    endtask

    task automatic load_hazards();
        begin_test();
        lw(17, 8, 12'h000);
        add(18, 17, 9);
        lw(19, 8, 12'h004);
        addi(19, 9, 12'h011);
        add(20, 19, 17);
        lw(21, 8, 12'h040);
        sw(21, 8, 12'h044);
        drain();
        check_regs();
        check_memory();
        end_test("load_hazards");
    endtask

    task automatic oitf_full();
        logic [11:0] imm;
        begin_test();
        for (int k = 0; k < `OITF_DEPTH + 2; k++) begin
            imm = 12'h050 + k * 9;
            addi(24 + k, 0, imm);
        end
        hold = 1'b1;
        for (int k = 0; k < `OITF_DEPTH; k++) begin
            imm = 12'h200 + k * 4;
            sw(24 + k, 0, imm);
        end
        // fifth store offered while every OITF entry is busy
        instr_valid = 1'b1;
        instr_word  = s_type(24 + `OITF_DEPTH, 0, 12'h200 + `OITF_DEPTH * 4);
        repeat (3) begin
            #1;
            check("instr_ready with OITF full", instr_ready, 0);
            @(negedge clk);
        end
        hold = 1'b0;
        for (int k = `OITF_DEPTH; k < `OITF_DEPTH + 2; k++) begin
            imm = 12'h200 + k * 4;
            sw(24 + k, 0, imm);
        end
        drain();
        check_memory();
        check("APB write count", got_wr.size(), exp_wr.size());
        if (got_wr.size() == exp_wr.size()) begin
            for (int i = 0; i < exp_wr.size(); i++) begin
                check($sformatf("APB write %0d address", i), got_wr[i], exp_wr[i]);
            end
        end
        end_test("oitf_full");
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================
    initial begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr_word  = '0;
        dbg_rdidx   = '0;
        hold        = 1'b0;
        checks      = 0;
        errors      = 0;
        test_base   = 0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = mem_model_i.mem[i];
        end

        reset_state();
        alu_ops();
        store_load();
        load_hazards();
        oitf_full();

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* exu_top.f */
+incdir+hw
hw/exu_pkg.sv
hw/apb_pkg.sv
hw/exu_disp_if.sv
hw/exu_disp.sv
hw/exu_oitf.sv
hw/exu_regfile.sv
hw/exu_lsu.sv
hw/exu_wbck.sv
hw/exu_top.sv
verification/apb_mem_model.sv
verification/exu_tb.sv
